// File: hdl/rv_isa_pkg.sv
`default_nettype none

// ==============================
// RV32 architectural encodings
// ==============================
package rv_isa_pkg;

  // Machine word width
  localparam int XLEN = 32;

  // Data and address word
  typedef logic [XLEN-1:0] xlen_t;

  // Register file index, x0..x31
  typedef logic [4:0] reg_addr_t;

  // Load/store funct3 field
  typedef logic [2:0] funct3_t;

  // Size codes
  // Low two bits give the access size, bit 2 marks an unsigned load
  localparam funct3_t F3_B  = 3'd0;
  localparam funct3_t F3_H  = 3'd1;
  localparam funct3_t F3_W  = 3'd2;
  localparam funct3_t F3_BU = 3'd4;
  localparam funct3_t F3_HU = 3'd5;

  // Trap cause carried down the pipe
  typedef logic [1:0] trap_code_t;

  // Load or store address not aligned to its size
  localparam trap_code_t TRAP_LDST_MISALIGN = 2'd2;

endpackage

`default_nettype wire

// File: hdl/rv_core_pkg.sv
`default_nettype none

// ==============================
// Pipeline-internal encodings
// ==============================
package rv_core_pkg;

  // Write-back result source
  typedef logic [2:0] res_src_t;

  // ALU output, also used by most instructions
  localparam res_src_t RES_ALU = 3'd0;
  // Formatted load data
  localparam res_src_t RES_LD  = 3'd1;
  // Multiply/divide unit result
  localparam res_src_t RES_M   = 3'd2;
  // Link value for JAL/JALR
  localparam res_src_t RES_PC4 = 3'd3;
  // Jump/branch target, used by AUIPC
  localparam res_src_t RES_TGT = 3'd4;

  // Byte lanes in one data word
  localparam int LANES = 4;

  // Per-lane write enable
  typedef logic [LANES-1:0] wstrb_t;

endpackage

`default_nettype wire

// File: hdl/rv_store_fmt.sv
`timescale 1ns/1ps
`default_nettype none

// Store formatter
// Replicates store data across the byte lanes and builds the strobe
module rv_store_fmt
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  wire xlen_t   data_i,
  input  wire [1:0]    byte_off_i,
  input  wire funct3_t funct3_i,
  output xlen_t        wdata_o,
  output wstrb_t       wstrb_o
);

  // Single-lane strobe at the addressed byte
  wstrb_t byte_strb;
  // Two-lane strobe for the addressed half
  wstrb_t half_strb;

  assign byte_strb = wstrb_t'(1) << byte_off_i;
  // Offset bit 1 picks upper or lower half
  assign half_strb = byte_off_i[1] ? 4'b1100 : 4'b0011;

  always_comb begin
    case (funct3_i[1:0])
      F3_B[1:0]: begin
        // Same byte on every lane, memory keeps only the strobed one
        wdata_o = {LANES{data_i[7:0]}};
        wstrb_o = byte_strb;
      end
      F3_H[1:0]: begin
        wdata_o = {2{data_i[15:0]}};
        wstrb_o = half_strb;
      end
      F3_W[1:0]: begin
        wdata_o = data_i;
        wstrb_o = '1;
      end
      default: begin
        // Reserved size, treat as word
        wdata_o = data_i;
        wstrb_o = '1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_load_fmt.sv
`timescale 1ns/1ps
`default_nettype none

// Load formatter
// Pulls the addressed byte or half out of the read word and extends it
module rv_load_fmt
  import rv_isa_pkg::*;
(
  input  wire xlen_t   rdata_i,
  input  wire [1:0]    byte_off_i,
  input  wire funct3_t funct3_i,
  output xlen_t        data_o
);

  // ==============================
  // Lane extraction
  // ==============================

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Byte offset times eight gives the bit position
  assign byte_sel = rdata_i[{byte_off_i, 3'b000} +: 8];

  // Only offset bit 1 matters for halves
  // Bit 0 set here is a misaligned access and is trapped upstream
  assign half_sel = rdata_i[{byte_off_i[1], 4'b0000} +: 16];

  // ==============================
  // Extension
  // ==============================

  always_comb begin
    case (funct3_i)
      F3_B: begin
        // Sign extend from bit 7
        data_o = {{(XLEN-8){byte_sel[7]}}, byte_sel};
      end
      F3_BU: begin
        data_o = {{(XLEN-8){1'b0}}, byte_sel};
      end
      F3_H: begin
        // Sign extend from bit 15
        data_o = {{(XLEN-16){half_sel[15]}}, half_sel};
      end
      F3_HU: begin
        data_o = {{(XLEN-16){1'b0}}, half_sel};
      end
      F3_W: begin
        data_o = rdata_i;
      end
      default: begin
        // Unused codes return the raw word
        data_o = rdata_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_mem_access.sv
`timescale 1ns/1ps
`default_nettype none

// Data-memory access and forwarding result for the MEM stage
module rv_mem_access
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  wire           accept_i,
  input  wire           mem_read_i,
  input  wire           mem_write_i,
  input  wire           trap_i,
  input  wire funct3_t  funct3_i,
  input  wire xlen_t    addr_i,
  input  wire xlen_t    store_data_i,
  input  wire xlen_t    dmem_rdata_i,
  input  wire xlen_t    alu_result_i,
  input  wire xlen_t    m_result_i,
  input  wire xlen_t    pc_plus4_i,
  input  wire xlen_t    jb_target_i,
  input  wire res_src_t res_src_i,
  output logic          dmem_ren_o,
  output logic          dmem_we_o,
  output xlen_t         dmem_raddr_o,
  output xlen_t         dmem_waddr_o,
  output xlen_t         dmem_wdata_o,
  output wstrb_t        dmem_wstrb_o,
  output logic          misalign_o,
  output logic          trap_o,
  output xlen_t         load_data_o,
  output xlen_t         result_o
);

  wstrb_t st_wstrb;

  // ==============================
  // Store and load formatting
  // ==============================

  rv_store_fmt u_store_fmt (
    .data_i    (store_data_i),
    .byte_off_i(addr_i[1:0]),
    .funct3_i  (funct3_i),
    .wdata_o   (dmem_wdata_o),
    .wstrb_o   (st_wstrb)
  );

  // Memory answers in the same cycle, so format here
  rv_load_fmt u_load_fmt (
    .rdata_i   (dmem_rdata_i),
    .byte_off_i(addr_i[1:0]),
    .funct3_i  (funct3_i),
    .data_o    (load_data_o)
  );

  // ==============================
  // Misalignment trap
  // ==============================

  always_comb begin
    misalign_o = 1'b0;
    // Only memory instructions can misalign
    if (mem_read_i || mem_write_i) begin
      case (funct3_i[1:0])
        F3_H[1:0]: misalign_o = addr_i[0];
        F3_W[1:0]: misalign_o = |addr_i[1:0];
        default:   misalign_o = 1'b0;
      endcase
    end
  end

  assign trap_o = trap_i | misalign_o;

  // ==============================
  // Memory strobes and addresses
  // ==============================

  // Any trap kills the access
  assign dmem_ren_o   = accept_i && mem_read_i && !trap_o;
  assign dmem_we_o    = accept_i && mem_write_i && !trap_o;
  // Word-aligned addresses, lanes chosen by the strobe
  assign dmem_raddr_o = {addr_i[XLEN-1:2], 2'b00};
  assign dmem_waddr_o = {addr_i[XLEN-1:2], 2'b00};
  assign dmem_wstrb_o = mem_write_i ? st_wstrb : '0;

  // ==============================
  // Forwarding result
  // ==============================

  always_comb begin
    case (res_src_i)
      RES_M:   result_o = m_result_i;
      RES_PC4: result_o = pc_plus4_i;
      RES_TGT: result_o = jb_target_i;
      // Loads forward through load_data_o instead
      RES_ALU, RES_LD: result_o = alu_result_i;
      default: result_o = alu_result_i;
    endcase
  end

  // One access per instruction, never both directions
  a_rw_exclusive: assert final (!(dmem_ren_o && dmem_we_o))
    else $error("read and write strobes both high");

  // A write must enable at least one lane
  a_we_has_strb: assert final (!dmem_we_o || (dmem_wstrb_o != '0))
    else $error("write strobe with empty byte strobe");

endmodule

`default_nettype wire

// File: hdl/rv_branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

// Branch and JALR resolution in the MEM stage
// Flags wrong predictions and drives the return stack
module rv_branch_resolve
  import rv_isa_pkg::*;
(
  input  wire            accept_i,
  input  wire            is_branch_i,
  input  wire            is_jalr_i,
  input  wire            is_jmp_i,
  input  wire            branch_taken_i,
  input  wire            bpred_taken_i,
  input  wire reg_addr_t rd_i,
  input  wire xlen_t     pc_plus4_i,
  input  wire xlen_t     jb_target_i,
  input  wire xlen_t     pred_target_i,
  output logic           ras_push_o,
  output logic           ras_pop_o,
  output logic           mispredicted_o,
  output logic           jalr_mispredicted_o,
  output xlen_t          redirect_pc_o
);

  logic branch_miss;
  logic jalr_miss;

  // ==============================
  // Miss detection
  // ==============================

  // Direction disagrees with the predictor
  assign branch_miss = is_branch_i && (branch_taken_i != bpred_taken_i);

  // JALR needs both a taken prediction and the right target
  assign jalr_miss = is_jalr_i && (!bpred_taken_i || (pred_target_i != jb_target_i));

  // Pulses only in the accept cycle
  assign jalr_mispredicted_o = accept_i && jalr_miss;
  assign mispredicted_o      = accept_i && (branch_miss || jalr_miss);

  // ==============================
  // Redirect target
  // ==============================

  always_comb begin
    // Taken branches and JALR go to the computed target
    redirect_pc_o = jb_target_i;
    // Predicted taken but fell through
    if (branch_miss && !branch_taken_i) begin
      redirect_pc_o = pc_plus4_i;
    end
  end

  // ==============================
  // Return stack
  // ==============================

  // Calls link into a real register, jumps to x0 do not push
  assign ras_push_o = accept_i && is_jmp_i && (rd_i != '0);
  // Every JALR is treated as a return
  assign ras_pop_o  = accept_i && is_jalr_i;

  // A miss needs a control-flow instruction behind it
  a_miss_has_cause: assert final (!mispredicted_o || is_branch_i || is_jalr_i)
    else $error("misprediction without branch or JALR");

endmodule

`default_nettype wire

// File: hdl/rv_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

// Pipeline boundary register for any packed payload
// Holds its value while advance_i is low
module rv_stage_reg #(
  parameter type payload_t       = logic,
  parameter bit  CLEAR_ON_BUBBLE = 1'b0
) (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           advance_i,
  input  wire           bubble_i,
  input  wire payload_t data_i,
  output payload_t      data_o
);

  // Bubble clearing only where the payload triggers actions
  logic clear;

  assign clear = CLEAR_ON_BUBBLE && bubble_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_o <= payload_t'('0);
    end else if (advance_i) begin
      if (clear) begin
        // Empty slot downstream sees all zeros
        data_o <= payload_t'('0);
      end else begin
        data_o <= data_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_stage_mem.sv
`timescale 1ns/1ps
`default_nettype none

// MEM stage of the five-stage RV32 pipeline
// Valid/ready in from EX, registered valid/ready out to WB
module rv_stage_mem
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  // EX side handshake
  input  wire             s_valid_i,
  output logic            s_ready_o,
  // From EX
  input  wire             reg_write_i,
  input  wire             mem_read_i,
  input  wire             mem_write_i,
  input  wire res_src_t   res_src_i,
  input  wire reg_addr_t  rd_i,
  input  wire funct3_t    funct3_i,
  input  wire xlen_t      alu_result_i,
  input  wire xlen_t      rs2_data_i,
  input  wire xlen_t      pc_plus4_i,
  input  wire xlen_t      jb_target_i,
  input  wire xlen_t      m_result_i,
  input  wire             is_branch_i,
  input  wire             is_jalr_i,
  input  wire             is_jmp_i,
  input  wire             branch_taken_i,
  input  wire             bpred_taken_i,
  input  wire xlen_t      pred_target_i,
  input  wire             trap_i,
  input  wire trap_code_t trap_code_i,
  // Data memory
  output logic            dmem_ren_o,
  output xlen_t           dmem_raddr_o,
  input  wire xlen_t      dmem_rdata_i,
  output logic            dmem_we_o,
  output xlen_t           dmem_waddr_o,
  output xlen_t           dmem_wdata_o,
  output wstrb_t          dmem_wstrb_o,
  // WB side handshake
  output logic            m_valid_o,
  input  wire             m_ready_i,
  // To WB
  output logic            reg_write_wb_o,
  output logic            trap_wb_o,
  output trap_code_t      trap_code_wb_o,
  output res_src_t        res_src_wb_o,
  output reg_addr_t       rd_wb_o,
  output xlen_t           alu_result_wb_o,
  output xlen_t           ld_data_wb_o,
  output xlen_t           pc_plus4_wb_o,
  output xlen_t           jb_target_wb_o,
  output xlen_t           m_result_wb_o,
  // Same-cycle forwarding and control flow
  output xlen_t           result_mem_o,
  output xlen_t           load_data_mem_o,
  output logic            ras_push_o,
  output logic            ras_pop_o,
  output logic            mispredicted_o,
  output logic            jalr_mispredicted_o,
  output xlen_t           redirect_pc_o
);

  // Payloads of the two boundary registers
  typedef struct packed {
    logic reg_write;
    logic trap;
  } ctrl_pl_t;

  typedef struct packed {
    trap_code_t trap_code;
    res_src_t   res_src;
    reg_addr_t  rd;
    xlen_t      alu_result;
    xlen_t      ld_data;
    xlen_t      pc_plus4;
    xlen_t      jb_target;
    xlen_t      m_result;
  } data_pl_t;

  logic     accept;
  logic     misalign;
  logic     trap;
  ctrl_pl_t ctrl_d;
  ctrl_pl_t ctrl_q;
  data_pl_t data_d;
  data_pl_t data_q;

  // ==============================
  // Handshake
  // ==============================

  // Take a new instruction when the output slot is empty or draining
  assign s_ready_o = !m_valid_o || m_ready_i;
  assign accept    = s_valid_i && s_ready_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid_o <= 1'b0;
    end else if (s_ready_o) begin
      m_valid_o <= s_valid_i;
    end
  end

  // ==============================
  // Memory access and branch check
  // ==============================

  rv_mem_access u_mem_access (
    .accept_i    (accept),
    .mem_read_i  (mem_read_i),
    .mem_write_i (mem_write_i),
    .trap_i      (trap_i),
    .funct3_i    (funct3_i),
    .addr_i      (alu_result_i),
    .store_data_i(rs2_data_i),
    .dmem_rdata_i(dmem_rdata_i),
    .alu_result_i(alu_result_i),
    .m_result_i  (m_result_i),
    .pc_plus4_i  (pc_plus4_i),
    .jb_target_i (jb_target_i),
    .res_src_i   (res_src_i),
    .dmem_ren_o  (dmem_ren_o),
    .dmem_we_o   (dmem_we_o),
    .dmem_raddr_o(dmem_raddr_o),
    .dmem_waddr_o(dmem_waddr_o),
    .dmem_wdata_o(dmem_wdata_o),
    .dmem_wstrb_o(dmem_wstrb_o),
    .misalign_o  (misalign),
    .trap_o      (trap),
    .load_data_o (load_data_mem_o),
    .result_o    (result_mem_o)
  );

  rv_branch_resolve u_branch_resolve (
    .accept_i           (accept),
    .is_branch_i        (is_branch_i),
    .is_jalr_i          (is_jalr_i),
    .is_jmp_i           (is_jmp_i),
    .branch_taken_i     (branch_taken_i),
    .bpred_taken_i      (bpred_taken_i),
    .rd_i               (rd_i),
    .pc_plus4_i         (pc_plus4_i),
    .jb_target_i        (jb_target_i),
    .pred_target_i      (pred_target_i),
    .ras_push_o         (ras_push_o),
    .ras_pop_o          (ras_pop_o),
    .mispredicted_o     (mispredicted_o),
    .jalr_mispredicted_o(jalr_mispredicted_o),
    .redirect_pc_o      (redirect_pc_o)
  );

  // ==============================
  // MEM/WB boundary
  // ==============================

  // Trapped instructions must not write the register file
  assign ctrl_d.reg_write = reg_write_i && !trap;
  assign ctrl_d.trap      = trap;

  // Misalignment found here overrides the incoming cause
  assign data_d.trap_code  = misalign ? TRAP_LDST_MISALIGN : trap_code_i;
  assign data_d.res_src    = res_src_i;
  assign data_d.rd         = rd_i;
  assign data_d.alu_result = alu_result_i;
  assign data_d.ld_data    = load_data_mem_o;
  assign data_d.pc_plus4   = pc_plus4_i;
  assign data_d.jb_target  = jb_target_i;
  assign data_d.m_result   = m_result_i;

  // Control bits zeroed on bubbles so WB can use them directly
  rv_stage_reg #(
    .payload_t      (ctrl_pl_t),
    .CLEAR_ON_BUBBLE(1'b1)
  ) u_ctrl_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(s_ready_o),
    .bubble_i (!s_valid_i),
    .data_i   (ctrl_d),
    .data_o   (ctrl_q)
  );

  // Data may go stale, qualified by m_valid_o
  rv_stage_reg #(
    .payload_t      (data_pl_t),
    .CLEAR_ON_BUBBLE(1'b0)
  ) u_data_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(s_ready_o),
    .bubble_i (!s_valid_i),
    .data_i   (data_d),
    .data_o   (data_q)
  );

  assign reg_write_wb_o  = ctrl_q.reg_write;
  assign trap_wb_o       = ctrl_q.trap;
  assign trap_code_wb_o  = data_q.trap_code;
  assign res_src_wb_o    = data_q.res_src;
  assign rd_wb_o         = data_q.rd;
  assign alu_result_wb_o = data_q.alu_result;
  assign ld_data_wb_o    = data_q.ld_data;
  assign pc_plus4_wb_o   = data_q.pc_plus4;
  assign jb_target_wb_o  = data_q.jb_target;
  assign m_result_wb_o   = data_q.m_result;

  // A presented result is not withdrawn until WB takes it
  a_m_valid_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_valid_o && !m_ready_i |=> m_valid_o
  ) else $error("m_valid dropped under back-pressure");

endmodule

`default_nettype wire

// File: bench/tb_stage_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stage_mem
  import rv_isa_pkg::*, rv_core_pkg::*;
();

  // ==============================
  // Trace layout
  // ==============================

  localparam int NL = 23;
  localparam int NF = 22;
  localparam int LIMIT = 8 * NL + 100;

  // Input columns
  localparam int C_CTRL = 0, C_SRC = 1, C_RD = 2, C_F3 = 3, C_TCODE = 4, C_ALU = 5;
  localparam int C_RS2 = 6, C_PC4 = 7, C_TGT = 8, C_MRES = 9, C_PRED = 10, C_RDATA = 11;
  // Expected same-cycle columns
  localparam int E_FLAGS = 12, E_STRB = 13, E_WDATA = 14, E_ADDR = 15, E_RES = 16;
  localparam int E_LOAD = 17, E_REDIR = 18;
  // Expected write-back columns
  localparam int E_WB = 19, E_CODE = 20, E_LDWB = 21;

  logic [31:0] trace_mem [0:NL*NF-1];

  logic clk, rst_n;
  logic s_valid_i, s_ready_o, m_valid_o, m_ready_i;
  logic reg_write_i, mem_read_i, mem_write_i, is_branch_i, is_jalr_i, is_jmp_i;
  logic branch_taken_i, bpred_taken_i, trap_i;
  res_src_t res_src_i;
  reg_addr_t rd_i;
  funct3_t funct3_i;
  trap_code_t trap_code_i;
  xlen_t alu_result_i, rs2_data_i, pc_plus4_i, jb_target_i, m_result_i, pred_target_i;
  xlen_t dmem_rdata_i;
  logic dmem_ren_o, dmem_we_o;
  xlen_t dmem_raddr_o, dmem_waddr_o, dmem_wdata_o;
  wstrb_t dmem_wstrb_o;
  logic reg_write_wb_o, trap_wb_o;
  trap_code_t trap_code_wb_o;
  res_src_t res_src_wb_o;
  reg_addr_t rd_wb_o;
  xlen_t alu_result_wb_o, ld_data_wb_o, pc_plus4_wb_o, jb_target_wb_o, m_result_wb_o;
  xlen_t result_mem_o, load_data_mem_o, redirect_pc_o;
  logic ras_push_o, ras_pop_o, mispredicted_o, jalr_mispredicted_o;

  int mismatches;
  int other_errors;
  logic [31:0] rng;

  rv_stage_mem UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==============================
  // Helpers
  // ==============================

  function automatic logic [31:0] field(input int line, input int col);
    return trace_mem[line*NF + col];
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got=%h exp=%h", name, got, exp);
    end
  endtask

  task automatic check_strb(input string name, input wstrb_t got, input wstrb_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got=%h exp=%h", name, got, exp);
    end
  endtask

  task automatic check_src(input string name, input res_src_t got, input res_src_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got=%h exp=%h", name, got, exp);
    end
  endtask

  task automatic check_code(input string name, input trap_code_t got, input trap_code_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got=%h exp=%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got=%h exp=%h", name, got, exp);
    end
  endtask

  // Put one trace line on the EX-side inputs
  task automatic drive_line(input int line);
    logic [31:0] c;
    c = field(line, C_CTRL);
    reg_write_i    = c[0];
    mem_read_i     = c[1];
    mem_write_i    = c[2];
    is_branch_i    = c[3];
    is_jalr_i      = c[4];
    is_jmp_i       = c[5];
    branch_taken_i = c[6];
    bpred_taken_i  = c[7];
    trap_i         = c[8];
    res_src_i      = res_src_t'(field(line, C_SRC));
    rd_i           = reg_addr_t'(field(line, C_RD));
    funct3_i       = funct3_t'(field(line, C_F3));
    trap_code_i    = trap_code_t'(field(line, C_TCODE));
    alu_result_i   = field(line, C_ALU);
    rs2_data_i     = field(line, C_RS2);
    pc_plus4_i     = field(line, C_PC4);
    jb_target_i    = field(line, C_TGT);
    m_result_i     = field(line, C_MRES);
    pred_target_i  = field(line, C_PRED);
    dmem_rdata_i   = field(line, C_RDATA);
  endtask

  // Same-cycle outputs of an accepted line
  task automatic check_accept(input int line);
    logic [31:0] f;
    f = field(line, E_FLAGS);
    check_bit("dmem_ren_o", dmem_ren_o, f[0]);
    check_bit("dmem_we_o", dmem_we_o, f[1]);
    check_bit("ras_push_o", ras_push_o, f[2]);
    check_bit("ras_pop_o", ras_pop_o, f[3]);
    check_bit("mispredicted_o", mispredicted_o, f[4]);
    check_bit("jalr_mispredicted_o", jalr_mispredicted_o, f[5]);
    check_strb("dmem_wstrb_o", dmem_wstrb_o, wstrb_t'(field(line, E_STRB)));
    check_word("dmem_wdata_o", dmem_wdata_o, field(line, E_WDATA));
    check_word("dmem_raddr_o", dmem_raddr_o, field(line, E_ADDR));
    check_word("dmem_waddr_o", dmem_waddr_o, field(line, E_ADDR));
    check_word("result_mem_o", result_mem_o, field(line, E_RES));
    check_word("load_data_mem_o", load_data_mem_o, field(line, E_LOAD));
    check_word("redirect_pc_o", redirect_pc_o, field(line, E_REDIR));
  endtask

  // Outside an accept no strobe or pulse may fire
  task automatic check_idle();
    check_bit("dmem_ren_o", dmem_ren_o, 1'b0);
    check_bit("dmem_we_o", dmem_we_o, 1'b0);
    check_bit("ras_push_o", ras_push_o, 1'b0);
    check_bit("ras_pop_o", ras_pop_o, 1'b0);
    check_bit("mispredicted_o", mispredicted_o, 1'b0);
    check_bit("jalr_mispredicted_o", jalr_mispredicted_o, 1'b0);
  endtask

  task automatic check_retire(input int line);
    logic [31:0] w;
    w = field(line, E_WB);
    check_bit("reg_write_wb_o", reg_write_wb_o, w[0]);
    check_bit("trap_wb_o", trap_wb_o, w[1]);
    check_code("trap_code_wb_o", trap_code_wb_o, trap_code_t'(field(line, E_CODE)));
    check_src("res_src_wb_o", res_src_wb_o, res_src_t'(field(line, C_SRC)));
    check_word("rd_wb_o", xlen_t'(rd_wb_o), field(line, C_RD));
    check_word("alu_result_wb_o", alu_result_wb_o, field(line, C_ALU));
    check_word("ld_data_wb_o", ld_data_wb_o, field(line, E_LDWB));
    check_word("pc_plus4_wb_o", pc_plus4_wb_o, field(line, C_PC4));
    check_word("jb_target_wb_o", jb_target_wb_o, field(line, C_TGT));
    check_word("m_result_wb_o", m_result_wb_o, field(line, C_MRES));
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial begin
    int idx;
    int cycles;
    int line_q[$];
    int head;
    logic exp_valid;
    logic holding;
    logic gap;
    mismatches = 0;
    other_errors = 0;
    rng = 32'd35;
    idx = 0;
    cycles = 0;
    holding = 1'b0;
    rst_n = 1'b0;
    s_valid_i = 1'b0;
    m_ready_i = 1'b0;
    $readmemh("bench/stage_mem_trace.txt", trace_mem);
    drive_line(0);
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    while ((idx < NL || line_q.size() != 0) && cycles < LIMIT) begin
      @(negedge clk);
      // Roughly one stall in three
      rng = xorshift(rng);
      m_ready_i = (rng % 3) != 0;
      // About one idle gap in four between lines
      // A presented line stays up until it is taken
      rng = xorshift(rng);
      gap = (rng % 4) == 0;
      if (idx < NL && (holding || !gap)) begin
        drive_line(idx);
        s_valid_i = 1'b1;
      end else begin
        s_valid_i = 1'b0;
      end

      // Sample in the low phase, well clear of the rising edge
      #5;
      // One-deep stage holds exactly the lines accepted and not yet retired
      exp_valid = (line_q.size() != 0);
      check_bit("m_valid_o", m_valid_o, exp_valid);
      check_bit("s_ready_o", s_ready_o, !exp_valid || m_ready_i);
      if (!exp_valid) begin
        // Empty slot carries cleared control bits
        check_bit("reg_write_wb_o", reg_write_wb_o, 1'b0);
        check_bit("trap_wb_o", trap_wb_o, 1'b0);
      end

      // Retire the oldest line first, a new accept may share the edge
      if (m_valid_o && m_ready_i) begin
        if (line_q.size() == 0) begin
          other_errors++;
          $display("Output was presented with no instruction outstanding");
        end else begin
          head = line_q.pop_front();
          check_retire(head);
        end
      end
      holding = 1'b0;
      if (s_valid_i && s_ready_o) begin
        check_accept(idx);
        line_q.push_back(idx);
        idx++;
      end else begin
        holding = s_valid_i;
        check_idle();
      end

      @(posedge clk);
      cycles++;
    end

    if (idx < NL || line_q.size() != 0) begin
      other_errors++;
      $display("Timed out after %0d cycles with %0d lines left", cycles, NL - idx);
    end
    $display("Errors: mismatches=%0d other=%0d", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/stage_mem_trace.txt
// ctrl src rd f3 tcode alu rs2 pc4 tgt mres pred rdata | flags strb wdata addr res load redir | wb code ldwb
// ctrl bits: rw rd wr br jalr jmp taken pred trap; flags bits: ren we push pop mis jmis
004 0 00 0 0 00000101 000000AB 00000100 00000200 00000300 00000000 00000000 02 2 ABABABAB 00000100 00000101 00000000 00000200 0 0 00000000
004 0 00 0 0 00000103 12345678 00000100 00000200 00000300 00000000 00000000 02 8 78787878 00000100 00000103 00000000 00000200 0 0 00000000
004 0 00 1 0 00000102 0000BEEF 00000100 00000200 00000300 00000000 00000000 02 C BEEFBEEF 00000100 00000102 00000000 00000200 0 0 00000000
004 0 00 1 0 00000104 CAFE1234 00000100 00000200 00000300 00000000 00000000 02 3 12341234 00000104 00000104 00000000 00000200 0 0 00000000
004 0 00 2 0 00000108 DEADBEEF 00000100 00000200 00000300 00000000 00000000 02 F DEADBEEF 00000108 00000108 00000000 00000200 0 0 00000000
003 1 05 0 0 00000202 00000000 00000100 00000200 00000300 00000000 11F23344 01 0 00000000 00000200 00000202 FFFFFFF2 00000200 1 0 FFFFFFF2
003 1 05 4 0 00000201 00000000 00000100 00000200 00000300 00000000 A1B2C3D4 01 0 00000000 00000200 00000201 000000C3 00000200 1 0 000000C3
003 1 05 1 0 00000206 00000000 00000100 00000200 00000300 00000000 80017FFF 01 0 00000000 00000204 00000206 FFFF8001 00000200 1 0 FFFF8001
003 1 05 5 0 00000208 00000000 00000100 00000200 00000300 00000000 12349ABC 01 0 00000000 00000208 00000208 00009ABC 00000200 1 0 00009ABC
003 1 05 2 0 0000020C 00000000 00000100 00000200 00000300 00000000 76543210 01 0 00000000 0000020C 0000020C 76543210 00000200 1 0 76543210
003 1 05 2 0 00000212 00000000 00000100 00000200 00000300 00000000 00000000 00 0 00000000 00000210 00000212 00000000 00000200 2 2 00000000
004 0 00 1 0 00000301 00005566 00000100 00000200 00000300 00000000 00000000 00 3 55665566 00000300 00000301 00000000 00000200 2 2 00000000
101 0 06 0 1 00000400 00000000 00000100 00000200 00000300 00000000 00000000 00 0 00000000 00000400 00000400 00000000 00000200 2 1 00000000
001 2 07 0 0 00000500 00000000 00000100 00000200 00000300 00000000 00000000 00 0 00000000 00000500 00000300 00000000 00000200 1 0 00000000
001 3 07 0 0 00000504 00000000 00000100 00000200 00000300 00000000 00000000 00 0 00000000 00000504 00000100 00000000 00000200 1 0 00000000
001 4 07 0 0 00000508 00000000 00000100 00000200 00000300 00000000 00000000 00 0 00000000 00000508 00000200 00000000 00000200 1 0 00000000
088 0 00 0 0 00000600 00000000 00000100 00000200 00000300 00000000 00000000 10 0 00000000 00000600 00000600 00000000 00000100 0 0 00000000
048 0 00 0 0 00000604 00000000 00000100 00000200 00000300 00000000 00000000 10 0 00000000 00000604 00000604 00000000 00000200 0 0 00000000
0C8 0 00 0 0 00000608 00000000 00000100 00000200 00000300 00000000 00000000 00 0 00000000 00000608 00000608 00000000 00000200 0 0 00000000
091 3 00 0 0 00000700 00000000 00000100 00000200 00000300 00000204 00000000 38 0 00000000 00000700 00000100 00000000 00000200 1 0 00000000
091 3 00 0 0 00000704 00000000 00000100 00000200 00000300 00000200 00000000 08 0 00000000 00000704 00000100 00000000 00000200 1 0 00000000
021 3 01 0 0 00000708 00000000 00000100 00000200 00000300 00000000 00000000 04 0 00000000 00000708 00000100 00000000 00000200 1 0 00000000
021 3 00 0 0 0000070C 00000000 00000100 00000200 00000300 00000000 00000000 00 0 00000000 0000070C 00000100 00000000 00000200 1 0 00000000

// File: files.f
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_store_fmt.sv
hdl/rv_load_fmt.sv
hdl/rv_mem_access.sv
hdl/rv_branch_resolve.sv
hdl/rv_stage_reg.sv
hdl/rv_stage_mem.sv
bench/tb_stage_mem.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_stage_mem
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^ALL CHECKS PASSED$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
